//--- nes_loader_pkg.sv
// Shared constants and types for the iNES cartridge loader
// Import into any module that needs the flags word, the header byte 8
// decode or the loader phases
package nes_loader_pkg;

	localparam int addr_w = 22; // Cartridge memory address width

	// CHR data lives in the upper half of cartridge memory
	localparam logic [addr_w-1:0] chr_base = {1'b1, {(addr_w - 1){1'b0}}};

	localparam int prg_page_shift = 14; // 16 KiB PRG pages
	localparam int chr_page_shift = 13; // 8 KiB CHR pages

	localparam int header_len = 16;

	// "NES" followed by an MS-DOS end of file
	localparam logic [31:0] ines_magic = {8'h4E, 8'h45, 8'h53, 8'h1A};

	// Mapper flags word, highest field first
	typedef struct packed {
		logic [5:0] pad;         // Always zero
		logic       saves;       // Battery backed save RAM
		logic [7:0] nes20_byte8; // Submapper and mapper bits 8..11
		logic       four_screen;
		logic       chr_ram;     // No CHR ROM on the cartridge
		logic       mirroring;   // 1 for vertical
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// Header byte 8 means different things under the two header formats
	typedef union packed {
		struct packed {
			logic [3:0] submapper;
			logic [3:0] mapper_hi;
		} nes20;
		logic [7:0] prg_ram_units; // Legacy iNES, 8 KiB units
	} hdr_byte8_u;

	typedef enum logic [2:0] {
		phase_header,
		phase_prg,
		phase_chr,
		phase_done,
		phase_error
	} load_phase_t;

endpackage

//--- ines_header_parser.sv
// Collects the 16 byte iNES header and decodes it into the mapper flags word
// Feed bytes on hdr_valid; results are valid from the hdr_done pulse until
// the next header starts
`timescale 1ns/10ps

module ines_header_parser (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          hdr_valid,
	input  logic [7:0]                    hdr_byte,
	input  logic                          invert_mirroring,
	output logic                          hdr_done,
	output logic                          hdr_ok,
	output nes_loader_pkg::mapper_flags_t flags,
	output logic [7:0]                    prg_pages,
	output logic [7:0]                    chr_pages
);
	import nes_loader_pkg::*;

	localparam int cnt_w = $clog2(header_len);

	logic [7:0]       hdr_mem [header_len];
	logic [cnt_w-1:0] byte_cnt;
	hdr_byte8_u       byte8;
	logic             is_nes20;
	logic             is_dirty;
	logic             magic_ok;

	// Smallest k with pages <= 2**k, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = k[2:0];
		end
		return code;
	endfunction

	// Header byte store
	always_ff @(posedge clk) begin
		if (hdr_valid)
			hdr_mem[byte_cnt] <= hdr_byte;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_cnt <= '0;
			hdr_done <= 1'b0;
		end else begin
			hdr_done <= hdr_valid && (byte_cnt == cnt_w'(header_len - 1)); // After the last byte
			if (hdr_valid)
				byte_cnt <= byte_cnt + 1'b1; // Wraps back to 0 for the next image
		end
	end

	assign prg_pages = hdr_mem[4];
	assign chr_pages = hdr_mem[5];
	assign byte8     = hdr_mem[8];

	assign magic_ok = ({hdr_mem[0], hdr_mem[1], hdr_mem[2], hdr_mem[3]} == ines_magic);
	assign hdr_ok   = magic_ok && !hdr_mem[6][2]; // Trainers are not supported

	assign is_nes20 = (hdr_mem[7][3:2] == 2'b10);

	// Old dumping tools left junk in the tail of legacy headers
	assign is_dirty = !is_nes20 && ((hdr_mem[9][7:1] != 7'd0)
		|| (hdr_mem[10] != 8'd0)
		|| (hdr_mem[11] != 8'd0)
		|| (hdr_mem[12] != 8'd0)
		|| (hdr_mem[13] != 8'd0)
		|| (hdr_mem[14] != 8'd0)
		|| (hdr_mem[15] != 8'd0));

	always_comb begin
		flags = '0;
		flags.mapper      = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};
		flags.prg_size    = size_code(prg_pages);
		flags.chr_size    = size_code(chr_pages);
		flags.mirroring   = hdr_mem[6][0] ^ invert_mirroring;
		flags.chr_ram     = (chr_pages == 8'd0);
		flags.four_screen = hdr_mem[6][3];
		flags.saves       = hdr_mem[6][1];
		// Byte 8 only carries mapper data in NES 2.0 headers
		if (is_nes20)
			flags.nes20_byte8 = {byte8.nes20.submapper, byte8.nes20.mapper_hi};
		else
			flags.nes20_byte8 = 8'h00;
	end

endmodule

//--- rom_address_gen.sv
// Address generator for the PRG and CHR payload sections
// Load with start_prg, then step once per written byte; moves to the CHR
// section by itself and pulses finished after the last byte
`timescale 1ns/10ps

module rom_address_gen (
	input  logic                             clk,
	input  logic                             reset_nes,
	input  logic                             start_prg,
	input  logic [7:0]                       prg_pages,
	input  logic [7:0]                       chr_pages,
	input  logic                             step,
	output logic [nes_loader_pkg::addr_w-1:0] addr,
	output logic                             in_chr,
	output logic                             finished
);
	import nes_loader_pkg::*;

	logic [addr_w-1:0] remaining; // Bytes left in the current section
	logic [addr_w-1:0] prg_bytes;
	logic [addr_w-1:0] chr_bytes;
	logic              active;
	logic              last_byte;

	assign prg_bytes = addr_w'(prg_pages) << prg_page_shift;
	assign chr_bytes = addr_w'(chr_pages) << chr_page_shift;
	assign last_byte = (remaining == addr_w'(1));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			addr      <= '0;
			remaining <= '0;
			active    <= 1'b0;
			in_chr    <= 1'b0;
			finished  <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (start_prg) begin
				addr   <= '0;
				in_chr <= 1'b0;
				if (prg_pages != 8'd0) begin
					remaining <= prg_bytes;
					active    <= 1'b1;
				end else if (chr_pages != 8'd0) begin // CHR only image
					remaining <= chr_bytes;
					addr      <= chr_base;
					in_chr    <= 1'b1;
					active    <= 1'b1;
				end else begin
					active   <= 1'b0;
					finished <= 1'b1;
				end
			end else if (active && step) begin
				if (!last_byte) begin
					addr      <= addr + 1'b1;
					remaining <= remaining - 1'b1;
				end else if (!in_chr && chr_pages != 8'd0) begin
					// End of PRG, continue with CHR
					addr      <= chr_base;
					remaining <= chr_bytes;
					in_chr    <= 1'b1;
				end else begin
					addr      <= addr + 1'b1;
					remaining <= '0;
					active    <= 1'b0;
					finished  <= 1'b1;
				end
			end
		end
	end

endmodule

//--- load_controller.sv
// Load sequencer: buffers the incoming image, feeds the header parser and
// issues payload writes. Upstream holds BUF_DEPTH credits, refunded on
// in_credit; memory hands back write credits on mem_credit
`timescale 1ns/10ps

module load_controller #(
	parameter int BUF_DEPTH   = 4,
	parameter int MEM_CREDITS = 2
) (
	input  logic                              clk,
	input  logic                              reset_nes,
	input  logic                              in_valid,
	input  logic [7:0]                        in_data,
	input  logic                              mem_credit,
	input  logic                              hdr_done,
	input  logic                              hdr_ok,
	input  nes_loader_pkg::mapper_flags_t     flags,
	input  logic [nes_loader_pkg::addr_w-1:0] addr,
	input  logic                              in_chr,
	input  logic                              finished,
	output logic                              in_credit,
	output logic                              hdr_valid,
	output logic [7:0]                        hdr_byte,
	output logic                              start_prg,
	output logic                              step,
	output logic                              mem_write,
	output logic [nes_loader_pkg::addr_w-1:0] mem_addr,
	output logic [7:0]                        mem_data,
	output nes_loader_pkg::mapper_flags_t     mapper_flags,
	output logic                              flags_valid,
	output logic                              busy,
	output logic                              done,
	output logic                              error
);
	import nes_loader_pkg::*;

	localparam int ptr_w  = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int fill_w = $clog2(BUF_DEPTH + 1);
	localparam int cred_w = $clog2(MEM_CREDITS + 1);
	localparam int hcnt_w = $clog2(header_len + 1);

	localparam logic [ptr_w-1:0] last_ptr = ptr_w'(BUF_DEPTH - 1);

	logic [7:0]        buf_mem [BUF_DEPTH];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [fill_w-1:0] fill;
	logic [cred_w-1:0] mem_cred;
	logic [hcnt_w-1:0] hdr_cnt;
	load_phase_t       phase;
	logic              have_byte;
	logic              pop;
	logic              payload;

	assign have_byte = (fill != '0);
	assign payload   = (phase == phase_prg) || (phase == phase_chr);

	always_comb begin
		case (phase)
			phase_header: pop = have_byte && (hdr_cnt != hcnt_w'(header_len));
			phase_prg,
			phase_chr:    pop = have_byte && (mem_cred != '0); // Stall on memory back-pressure
			default:      pop = have_byte; // Drain whatever is left
		endcase
	end

	assign hdr_valid = pop && (phase == phase_header);
	assign hdr_byte  = buf_mem[rd_ptr];
	assign mem_write = pop && payload;
	assign mem_addr  = addr;
	assign mem_data  = buf_mem[rd_ptr];
	assign step      = mem_write;
	assign start_prg = hdr_done && hdr_ok && (phase == phase_header);

	// Input FIFO, the source never pushes without a credit
	always_ff @(posedge clk) begin
		if (in_valid)
			buf_mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			fill      <= '0;
			in_credit <= 1'b0;
		end else begin
			in_credit <= pop; // One credit back per byte taken
			if (in_valid)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mem_cred <= cred_w'(MEM_CREDITS);
		end else begin
			case ({mem_write, mem_credit})
				2'b10:   mem_cred <= mem_cred - 1'b1;
				2'b01:   mem_cred <= mem_cred + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_done)
			mapper_flags <= flags;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			phase       <= phase_header;
			hdr_cnt     <= '0;
			flags_valid <= 1'b0;
			busy        <= 1'b0;
			done        <= 1'b0;
			error       <= 1'b0;
		end else begin
			if (hdr_valid)
				hdr_cnt <= hdr_cnt + 1'b1;
			if (in_valid && phase == phase_header)
				busy <= 1'b1; // First byte of the image
			case (phase)
				phase_header: begin
					if (hdr_done) begin
						flags_valid <= 1'b1;
						if (hdr_ok) begin
							phase <= phase_prg;
						end else begin
							phase <= phase_error;
							error <= 1'b1;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
				end
				phase_prg, phase_chr: begin
					if (finished) begin
						phase <= phase_done;
						done  <= 1'b1;
						busy  <= 1'b0;
					end else if (in_chr) begin
						phase <= phase_chr;
					end
				end
				default: ; // Done and error hold until reset
			endcase
		end
	end

endmodule

//--- nes_loader_top.sv
// iNES cartridge loader top level
// Takes the image as a credit flow controlled byte stream and writes PRG
// and CHR into cartridge memory, also credit flow controlled
`timescale 1ns/10ps

module nes_loader_top #(
	parameter int BUF_DEPTH   = 4,
	parameter int MEM_CREDITS = 2
) (
	input  logic                              clk,
	input  logic                              reset_nes,
	input  logic                              in_valid,
	input  logic [7:0]                        in_data,
	input  logic                              invert_mirroring,
	input  logic                              mem_credit,
	output logic                              in_credit,
	output logic                              mem_write,
	output logic [nes_loader_pkg::addr_w-1:0] mem_addr,
	output logic [7:0]                        mem_data,
	output nes_loader_pkg::mapper_flags_t     mapper_flags,
	output logic                              flags_valid,
	output logic                              busy,
	output logic                              done,
	output logic                              error
);
	import nes_loader_pkg::*;

	logic              hdr_valid;
	logic [7:0]        hdr_byte;
	logic              hdr_done;
	logic              hdr_ok;
	mapper_flags_t     flags;
	logic [7:0]        prg_pages;
	logic [7:0]        chr_pages;
	logic              start_prg;
	logic              step;
	logic [addr_w-1:0] addr;
	logic              in_chr;
	logic              finished;

	load_controller #(
		.BUF_DEPTH   (BUF_DEPTH),
		.MEM_CREDITS (MEM_CREDITS)
	) u_load_controller (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.in_valid     (in_valid),
		.in_data      (in_data),
		.mem_credit   (mem_credit),
		.hdr_done     (hdr_done),
		.hdr_ok       (hdr_ok),
		.flags        (flags),
		.addr         (addr),
		.in_chr       (in_chr),
		.finished     (finished),
		.in_credit    (in_credit),
		.hdr_valid    (hdr_valid),
		.hdr_byte     (hdr_byte),
		.start_prg    (start_prg),
		.step         (step),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.mapper_flags (mapper_flags),
		.flags_valid  (flags_valid),
		.busy         (busy),
		.done         (done),
		.error        (error)
	);

	ines_header_parser u_ines_header_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.hdr_valid        (hdr_valid),
		.hdr_byte         (hdr_byte),
		.invert_mirroring (invert_mirroring),
		.hdr_done         (hdr_done),
		.hdr_ok           (hdr_ok),
		.flags            (flags),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages)
	);

	rom_address_gen u_rom_address_gen (
		.clk       (clk),
		.reset_nes (reset_nes),
		.start_prg (start_prg),
		.prg_pages (prg_pages),
		.chr_pages (chr_pages),
		.step      (step),
		.addr      (addr),
		.in_chr    (in_chr),
		.finished  (finished)
	);

endmodule

//--- loader_checker.sv
// Watches the loader ports and compares payload writes and the flags word
// against the values that the testbench queues for each image
// Also tracks both credit loops and keeps the error count
`timescale 1ns/10ps

module loader_checker #(
	parameter int MEM_CREDITS = 2
) (
	input logic                              clk,
	input logic                              reset_nes,
	input logic                              in_valid,
	input logic                              in_credit,
	input logic                              mem_write,
	input logic [nes_loader_pkg::addr_w-1:0] mem_addr,
	input logic [7:0]                        mem_data,
	input logic                              mem_credit,
	input nes_loader_pkg::mapper_flags_t     mapper_flags,
	input logic                              flags_valid,
	input logic                              busy,
	input logic                              done,
	input logic                              error
);
	import nes_loader_pkg::*;

	int                errors = 0;
	int                writes_seen = 0;
	int                mem_cred;     // Own copy of the DUT's memory credits
	int                bytes_sent;
	int                credits_back;
	logic [addr_w-1:0] exp_addr [$];
	logic [7:0]        exp_data [$];
	mapper_flags_t     exp_flags;
	logic              exp_error;
	logic              flags_seen = 1'b0;
	logic              done_seen = 1'b0;

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic begin_image(input mapper_flags_t f, input logic err);
		exp_flags  = f;
		exp_error  = err;
		flags_seen = 1'b0;
		done_seen  = 1'b0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic expect_write(input logic [addr_w-1:0] a, input logic [7:0] d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic end_image();
		if (exp_addr.size() != 0)
			note_failure($sformatf("%0d expected writes never issued", exp_addr.size()));
		if (!flags_seen)
			note_failure("flags_valid never rose");
		if (!done_seen)
			note_failure("done never rose");
	endtask

	// Outputs right after reset
	task automatic check_idle();
		compare_value("mem_write", 0, mem_write);
		compare_value("in_credit", 0, in_credit);
		compare_value("busy", 0, busy);
		compare_value("done", 0, done);
		compare_value("error", 0, error);
		compare_value("flags_valid", 0, flags_valid);
	endtask

	task automatic print_summary();
		$display("summary: %0d writes checked, %0d errors", writes_seen, errors);
	endtask

	always @(posedge clk) begin
		if (reset_nes) begin
			mem_cred     = MEM_CREDITS;
			bytes_sent   = 0;
			credits_back = 0;
		end else begin
			if (mem_write) begin
				if (mem_cred == 0)
					note_failure("mem_write issued without a memory credit");
				if (!busy)
					note_failure("mem_write while busy is low");
				if (exp_addr.size() == 0) begin
					note_failure("mem_write when no write was expected");
				end else begin
					compare_value("mem_addr", exp_addr.pop_front(), mem_addr);
					compare_value("mem_data", exp_data.pop_front(), mem_data);
					writes_seen++;
				end
			end
			mem_cred     = mem_cred - int'(mem_write) + int'(mem_credit);
			bytes_sent   = bytes_sent + int'(in_valid);
			credits_back = credits_back + int'(in_credit);
			if (credits_back > bytes_sent)
				note_failure("more in_credit pulses than bytes sent");
			if (flags_valid && !flags_seen) begin
				flags_seen = 1'b1;
				compare_value("mapper_flags", exp_flags, mapper_flags);
			end
			if (done && !done_seen) begin
				done_seen = 1'b1;
				compare_value("error", exp_error, error);
				compare_value("busy", 0, busy); // Drops with done
			end
		end
	end

endmodule

//--- tb_nes_loader.sv
// Testbench for the iNES loader: streams six images through the DUT with
// credit flow control on both sides; loader_checker does the comparing
`timescale 1ns/10ps

module tb_nes_loader;
	import nes_loader_pkg::*;

	localparam int BUF_DEPTH   = 4;
	localparam int MEM_CREDITS = 2;
	localparam int n_tests     = 6;
	localparam int bad_tail    = 64; // Bytes sent after a rejected header

	logic              clk = 1'b0;
	logic              reset_nes;
	logic              in_valid;
	logic [7:0]        in_data;
	logic              invert_mirroring;
	logic              mem_credit = 1'b0;
	logic              in_credit;
	logic              mem_write;
	logic [addr_w-1:0] mem_addr;
	logic [7:0]        mem_data;
	mapper_flags_t     mapper_flags;
	logic              flags_valid;
	logic              busy;
	logic              done;
	logic              error;
	logic [7:0]        hdr [16];
	int                src_credits;
	int                mem_cycle = 0;
	int                credit_due [$]; // Cycle at which each write credit returns

	always #4 clk = ~clk;

	nes_loader_top #(
		.BUF_DEPTH   (BUF_DEPTH),
		.MEM_CREDITS (MEM_CREDITS)
	) u_nes_loader_top (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_valid         (in_valid),
		.in_data          (in_data),
		.invert_mirroring (invert_mirroring),
		.mem_credit       (mem_credit),
		.in_credit        (in_credit),
		.mem_write        (mem_write),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mapper_flags     (mapper_flags),
		.flags_valid      (flags_valid),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	loader_checker #(
		.MEM_CREDITS (MEM_CREDITS)
	) u_loader_checker (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.in_valid     (in_valid),
		.in_credit    (in_credit),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.mem_credit   (mem_credit),
		.mapper_flags (mapper_flags),
		.flags_valid  (flags_valid),
		.busy         (busy),
		.done         (done),
		.error        (error)
	);

	// Header bytes 0 to 15, byte 0 in the top bits
	function automatic logic [127:0] header_word(input int t);
		case (t)
			0:       return 128'h4E45531A_01013140_02000000_00000000; // Legacy
			1:       return 128'h4E45531A_01011228_31000000_05000000; // NES 2.0
			2:       return 128'h4E45531A_01020170_31000000_44000000; // Dirty tail
			3:       return 128'h4E455A1A_01010000_00000000_00000000; // Bad signature
			4:       return 128'h4E45531A_01010400_00000000_00000000; // Trainer
			default: return 128'h4E45531A_01000A00_00000000_00000000; // CHR RAM
		endcase
	endfunction

	function automatic logic rejected(input int t);
		return (t == 3) || (t == 4);
	endfunction

	function automatic int payload_len(input int t);
		logic [127:0] w;
		w = header_word(t);
		if (rejected(t))
			return bad_tail;
		return (int'(w[95:88]) << 14) + (int'(w[87:80]) << 13);
	endfunction

	function automatic logic [7:0] payload_byte(input int t, input int i);
		return 8'(i ^ (i >> 8) ^ (i >> 16) ^ (t * 37));
	endfunction

	function automatic logic [2:0] page_code(input logic [7:0] pages);
		int code;
		code = 0;
		while (code < 7 && (1 << code) < pages)
			code++;
		return 3'(code);
	endfunction

	// Reference flags word built from hdr[] by the iNES decode rules
	function automatic logic [31:0] expected_flags(input logic inv);
		logic nes20;
		logic dirty;
		nes20 = (hdr[7][3:2] == 2'b10);
		dirty = !nes20 && ((hdr[9][7:1] != 0)
			|| ({hdr[10], hdr[11], hdr[12], hdr[13], hdr[14], hdr[15]} != 0));
		return {6'b0, hdr[6][1], nes20 ? hdr[8] : 8'h00, hdr[6][3], hdr[5] == 8'd0,
			hdr[6][0] ^ inv, page_code(hdr[5]), page_code(hdr[4]),
			dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		reset_nes = 1'b1;
		in_valid  = 1'b0;
		repeat (3) @(negedge clk);
		reset_nes   = 1'b0;
		src_credits = BUF_DEPTH;
	endtask

	// Sends one byte as soon as a credit is held
	task automatic send_byte(input logic [7:0] b);
		while (src_credits == 0) begin
			in_valid = 1'b0;
			@(negedge clk);
			if (in_credit)
				src_credits++;
		end
		in_valid = 1'b1;
		in_data  = b;
		src_credits--;
		@(negedge clk);
		if (in_credit)
			src_credits++;
	endtask

	task automatic run_image(input int t);
		logic [127:0]      w;
		logic [addr_w-1:0] waddr;
		int                prg_len;
		int                len;
		w = header_word(t);
		for (int i = 0; i < 16; i++)
			hdr[i] = w[127 - 8 * i -: 8];
		invert_mirroring = (t == 0);
		apply_reset();
		u_loader_checker.check_idle();
		u_loader_checker.begin_image(expected_flags(invert_mirroring), rejected(t));
		len     = payload_len(t);
		prg_len = int'(hdr[4]) << 14;
		for (int i = 0; i < len && !rejected(t); i++) begin
			waddr = (i < prg_len) ? addr_w'(i) : chr_base + addr_w'(i - prg_len);
			u_loader_checker.expect_write(waddr, payload_byte(t, i));
		end
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i]);
		for (int i = 0; i < len; i++)
			send_byte(payload_byte(t, i));
		in_valid = 1'b0;
		// Let the buffer drain and every memory credit come home
		while (!done || src_credits != BUF_DEPTH || credit_due.size() != 0) begin
			@(negedge clk);
			if (in_credit)
				src_credits++;
		end
		u_loader_checker.end_image();
	endtask

	// Memory model, each write credit comes back 0 to 5 cycles later
	always @(posedge clk) begin
		if (reset_nes)
			credit_due.delete();
		else if (mem_write)
			credit_due.push_back(mem_cycle + 1 + int'($urandom % 6));
		mem_cycle++;
	end

	always @(negedge clk) begin : credit_return
		int idx;
		idx = -1;
		for (int i = 0; i < credit_due.size(); i++)
			if (idx < 0 && credit_due[i] <= mem_cycle)
				idx = i;
		mem_credit = (idx >= 0);
		if (idx >= 0)
			credit_due.delete(idx);
	end

	initial begin
		void'($urandom(17557));
		reset_nes        = 1'b1;
		in_valid         = 1'b0;
		in_data          = 8'h00;
		invert_mirroring = 1'b0;
		for (int t = 0; t < n_tests; t++)
			run_image(t);
		u_loader_checker.print_summary();
		if (u_loader_checker.errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog sized from the images, 8 cycles per byte plus slack
	initial begin
		int limit;
		limit = 2000;
		for (int t = 0; t < n_tests; t++)
			limit += (header_len + payload_len(t)) * 8;
		repeat (limit) @(posedge clk);
		$display("timeout: loader did not finish within %0d cycles", limit);
		u_loader_checker.print_summary();
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sources.f
nes_loader_pkg.sv
ines_header_parser.sv
rom_address_gen.sv
load_controller.sv
nes_loader_top.sv
loader_checker.sv
tb_nes_loader.sv

//--- Bender.yml
package:
  name: nes_loader

sources:
  - nes_loader_pkg.sv
  - ines_header_parser.sv
  - rom_address_gen.sv
  - load_controller.sv
  - nes_loader_top.sv
  - target: test
    files:
      - loader_checker.sv
      - tb_nes_loader.sv
